/* cam_ctrl_config.svh */
/*
  Build-time sizes, trigger defaults and version fields for the camera controller.
  Include in any file that needs them; the guard keeps repeated includes harmless.
*/
`ifndef CAM_CTRL_CONFIG_SVH
`define CAM_CTRL_CONFIG_SVH

// Sensor array shape
`define CAM_COUNT 3
`define LANE_COUNT 8

// Width of one IDELAY tap setting
`define TAP_W 5

// Register port widths, word addressed
`define REG_ADDR_W 8
`define REG_DATA_W 32

// Trigger values after reset
`define DEFAULT_TRIG_LEN 100
// About 200 Hz at a 74 MHz register clock
`define DEFAULT_TRIG_PERIOD 370000

// Version word fields
// Major sits in bits 31:28
`define VER_MAJOR 4'd1
// Minor sits in bits 27:20
`define VER_MINOR 8'd0
// Revision sits in bits 19:16
`define VER_REV 4'd0

`endif

/* cam_ctrl_pkg.sv */
/*
  Types shared by the register file, the trigger generators and the top level:
  register address map, control bit positions and the request/response structs.
*/
`include "cam_ctrl_config.svh"

package cam_ctrl_pkg;

  // Word address map
  typedef enum logic [`REG_ADDR_W-1:0] {
    REG_CONTROL     = 0,
    REG_TRIG_WIDTH  = 3,
    REG_TRIG_PERIOD = 4,
    REG_CAM_COUNT   = 5,
    REG_LANE_COUNT  = 6,
    REG_TAP_START   = 16,
    REG_VERSION     = 40
  } reg_addr_e;

  // Control word bits
  localparam int CTRL_CLEAR      = 0;
  localparam int CTRL_TAP_RST    = 1;
  localparam int CTRL_TRIG_EN    = 2;
  localparam int CTRL_SERDES_RST = 4;
  localparam int CTRL_CAM_RST    = 5;
  localparam int CTRL_POWER0     = 12;
  localparam int CTRL_POWER1     = 13;
  localparam int CTRL_POWER2     = 14;

  // Single-cycle register request, strobes never high together
  typedef struct packed {
    logic                   wr_stb;
    logic                   rd_stb;
    logic [`REG_ADDR_W-1:0] addr;
    logic [`REG_DATA_W-1:0] wdata;
  } reg_req_t;

  typedef struct packed {
    logic                   rd_valid;
    logic [`REG_DATA_W-1:0] rdata;
    logic                   addr_err;
  } reg_rsp_t;

  // Shared by every trigger generator
  typedef struct packed {
    logic                   enable;
    logic                   restart;
    logic [`REG_DATA_W-1:0] pulse_width;
    logic [`REG_DATA_W-1:0] period;
  } trig_cfg_t;

endpackage

/* cam_reg_file.sv */
/*
  Register block of the camera controller: decodes single-cycle requests, holds
  control, trigger and tap settings, and answers reads one cycle later.
*/
`include "cam_ctrl_config.svh"

module cam_reg_file
  import cam_ctrl_pkg::*;
(
  input  logic                                         i_axi_clk,
  input  logic                                         i_axi_rst,
  input  reg_req_t                                     i_req,
  output reg_rsp_t                                     o_rsp,
  output trig_cfg_t                                    o_trig_cfg,
  output logic [`CAM_COUNT-1:0]                        o_power_en,
  output logic                                         o_xclear_n,
  output logic                                         o_tap_delay_rst,
  output logic                                         o_serdes_clk_rst,
  output logic [`CAM_COUNT-1:0][`LANE_COUNT*`TAP_W-1:0] o_tap_data
);

  localparam int AW         = `REG_ADDR_W;
  localparam int LANE_IDX_W = $clog2(`LANE_COUNT);
  localparam int CAM_IDX_W  = $clog2(`CAM_COUNT);
  // First address past the tap block
  localparam logic [AW-1:0] TAP_END = AW'(REG_TAP_START + `CAM_COUNT * `LANE_COUNT);

  // Control levels
  logic                     r_clear;
  logic                     r_trig_en;
  logic [`CAM_COUNT-1:0]    r_power_en;
  // One-cycle strobes
  logic                     r_tap_delay_rst;
  logic                     r_serdes_clk_rst;

  logic [`REG_DATA_W-1:0]   r_trig_width;
  logic [`REG_DATA_W-1:0]   r_trig_period;
  logic [`CAM_COUNT-1:0][`LANE_COUNT-1:0][`TAP_W-1:0] r_tap;

  logic                     r_rd_valid;
  logic                     r_addr_err;
  logic [`REG_DATA_W-1:0]   r_rdata;

  logic                     w_ctrl_wr;
  logic                     w_addr_bad;
  logic                     w_tap_hit;
  logic [AW-1:0]            w_tap_off;
  logic [CAM_IDX_W-1:0]     w_tap_cam;
  logic [LANE_IDX_W-1:0]    w_tap_lane;
  logic [`REG_DATA_W-1:0]   w_rd_mux;

  // Address decode
  assign w_ctrl_wr  = i_req.wr_stb && (i_req.addr == REG_CONTROL);
  assign w_addr_bad = i_req.addr > REG_VERSION;
  assign w_tap_hit  = (i_req.addr >= REG_TAP_START) && (i_req.addr < TAP_END);
  assign w_tap_off  = i_req.addr - REG_TAP_START;
  // Eight lanes per camera, so the offset splits into camera and lane fields
  assign w_tap_cam  = w_tap_off[LANE_IDX_W +: CAM_IDX_W];
  assign w_tap_lane = w_tap_off[LANE_IDX_W-1:0];

  always_ff @(posedge i_axi_clk) begin
    if (i_axi_rst) begin
      r_clear          <= 1'b0;
      r_trig_en        <= 1'b0;
      r_power_en       <= '0;
      r_tap_delay_rst  <= 1'b0;
      r_serdes_clk_rst <= 1'b0;
      r_trig_width     <= `DEFAULT_TRIG_LEN;
      r_trig_period    <= `DEFAULT_TRIG_PERIOD;
      r_tap            <= '0;
    end else begin
      r_tap_delay_rst  <= 1'b0;
      r_serdes_clk_rst <= 1'b0;
      if (i_req.wr_stb) begin
        case (i_req.addr)
          REG_CONTROL: begin
            r_clear          <= i_req.wdata[CTRL_CLEAR];
            r_trig_en        <= i_req.wdata[CTRL_TRIG_EN];
            r_power_en       <= {i_req.wdata[CTRL_POWER2],
                                 i_req.wdata[CTRL_POWER1],
                                 i_req.wdata[CTRL_POWER0]};
            r_tap_delay_rst  <= i_req.wdata[CTRL_TAP_RST];
            r_serdes_clk_rst <= i_req.wdata[CTRL_SERDES_RST];
          end
          REG_TRIG_WIDTH: begin
            r_trig_width <= i_req.wdata;
          end
          REG_TRIG_PERIOD: begin
            r_trig_period <= i_req.wdata;
          end
          default: begin
            // Read-only and unmapped addresses fall through here
            if (w_tap_hit) begin
              r_tap[w_tap_cam][w_tap_lane] <= i_req.wdata[`TAP_W-1:0];
            end
          end
        endcase
      end
    end
  end

  // Read data select
  always_comb begin
    w_rd_mux = '0;
    case (i_req.addr)
      REG_CONTROL: begin
        w_rd_mux[CTRL_CLEAR]   = r_clear;
        w_rd_mux[CTRL_TRIG_EN] = r_trig_en;
        w_rd_mux[CTRL_POWER0]  = r_power_en[0];
        w_rd_mux[CTRL_POWER1]  = r_power_en[1];
        w_rd_mux[CTRL_POWER2]  = r_power_en[2];
      end
      REG_TRIG_WIDTH:  w_rd_mux = r_trig_width;
      REG_TRIG_PERIOD: w_rd_mux = r_trig_period;
      REG_CAM_COUNT:   w_rd_mux = `CAM_COUNT;
      REG_LANE_COUNT:  w_rd_mux = `LANE_COUNT;
      REG_VERSION:     w_rd_mux = {`VER_MAJOR, `VER_MINOR, `VER_REV, 16'h0000};
      default: begin
        if (w_tap_hit) begin
          w_rd_mux[`TAP_W-1:0] = r_tap[w_tap_cam][w_tap_lane];
        end
      end
    endcase
  end

  // Response flags, one cycle after the request
  always_ff @(posedge i_axi_clk) begin
    if (i_axi_rst) begin
      r_rd_valid <= 1'b0;
      r_addr_err <= 1'b0;
    end else begin
      r_rd_valid <= i_req.rd_stb;
      r_addr_err <= (i_req.rd_stb || i_req.wr_stb) && w_addr_bad;
    end
  end

  always_ff @(posedge i_axi_clk) begin
    if (i_req.rd_stb) begin
      r_rdata <= w_rd_mux;
    end
  end

  assign o_rsp.rd_valid = r_rd_valid;
  assign o_rsp.rdata    = r_rdata;
  assign o_rsp.addr_err = r_addr_err;

  // Camera reset acts on the write cycle itself
  assign o_trig_cfg.enable      = r_trig_en;
  assign o_trig_cfg.restart     = w_ctrl_wr && i_req.wdata[CTRL_CAM_RST];
  assign o_trig_cfg.pulse_width = r_trig_width;
  assign o_trig_cfg.period      = r_trig_period;

  assign o_power_en       = r_power_en;
  assign o_xclear_n       = ~r_clear;
  assign o_tap_delay_rst  = r_tap_delay_rst;
  assign o_serdes_clk_rst = r_serdes_clk_rst;
  assign o_tap_data       = r_tap;

endmodule

/* cam_trigger_gen.sv */
/*
  Trigger pulse generator for one camera. Counts through the programmed period
  and holds the trigger high for the first pulse_width counts of each period.
*/
`include "cam_ctrl_config.svh"

module cam_trigger_gen
  import cam_ctrl_pkg::*;
(
  input  logic      i_axi_clk,
  input  logic      i_axi_rst,
  input  trig_cfg_t i_cfg,
  output logic      o_trigger
);

  logic [`REG_DATA_W-1:0] r_count;
  logic                   w_wrap;

  // Last count of the period, or past it after a shorter period is written
  assign w_wrap = r_count >= (i_cfg.period - 1);

  always_ff @(posedge i_axi_clk) begin
    if (i_axi_rst) begin
      r_count <= '0;
    end else if (!i_cfg.enable || i_cfg.restart) begin
      // Held at zero while disabled so the first enabled cycle fires
      r_count <= '0;
    end else if (w_wrap) begin
      r_count <= '0;
    end else begin
      r_count <= r_count + 1;
    end
  end

  // High at the start of every period
  assign o_trigger = i_cfg.enable && (r_count < i_cfg.pulse_width);

endmodule

/* cam_ctrl_top.sv */
/*
  Control top of the three-camera sensor interface. Joins the register block
  to one trigger generator per camera and brings the controls out to ports.
*/
`include "cam_ctrl_config.svh"

module cam_ctrl_top
  import cam_ctrl_pkg::*;
(
  input  logic                                         i_axi_clk,
  input  logic                                         i_axi_rst,
  input  reg_req_t                                     i_req,
  output reg_rsp_t                                     o_rsp,
  output logic [`CAM_COUNT-1:0]                        o_trigger,
  output logic [`CAM_COUNT-1:0]                        o_power_en,
  output logic                                         o_xclear_n,
  output logic                                         o_tap_delay_rst,
  output logic                                         o_serdes_clk_rst,
  output logic [`CAM_COUNT-1:0][`LANE_COUNT*`TAP_W-1:0] o_tap_data
);

  logic      w_axi_rst;
  trig_cfg_t w_trig_cfg;

  // Reset is active high at the port
  assign w_axi_rst = i_axi_rst;

  cam_reg_file u_reg_file (
    .i_axi_clk        (i_axi_clk),
    .i_axi_rst        (w_axi_rst),
    .i_req            (i_req),
    .o_rsp            (o_rsp),
    .o_trig_cfg       (w_trig_cfg),
    .o_power_en       (o_power_en),
    .o_xclear_n       (o_xclear_n),
    .o_tap_delay_rst  (o_tap_delay_rst),
    .o_serdes_clk_rst (o_serdes_clk_rst),
    .o_tap_data       (o_tap_data)
  );

  // All cameras share one width, period and enable
  for (genvar gi = 0; gi < `CAM_COUNT; gi++) begin : g_cam
    cam_trigger_gen u_trig_gen (
      .i_axi_clk (i_axi_clk),
      .i_axi_rst (w_axi_rst),
      .i_cfg     (w_trig_cfg),
      .o_trigger (o_trigger[gi])
    );
  end

endmodule

/* cam_ctrl_sva.sv */
/*
  Concurrent checks on the port timing of cam_ctrl_top, attached by bind.
*/
`include "cam_ctrl_config.svh"

module cam_ctrl_sva
  import cam_ctrl_pkg::*;
(
  input logic                  i_axi_clk,
  input logic                  i_axi_rst,
  input reg_req_t              i_req,
  input reg_rsp_t              i_rsp,
  input logic [`CAM_COUNT-1:0] i_trigger,
  input logic                  i_tap_delay_rst,
  input logic                  i_serdes_clk_rst
);

  logic r_trig_en;

  // Trigger enable as last written through the register port
  always_ff @(posedge i_axi_clk) begin
    if (i_axi_rst) begin
      r_trig_en <= 1'b0;
    end else if (i_req.wr_stb && (i_req.addr == REG_CONTROL)) begin
      r_trig_en <= i_req.wdata[CTRL_TRIG_EN];
    end
  end

  // One response per read, exactly one cycle later
  a_rd_valid_follows: assert property (@(posedge i_axi_clk) disable iff (i_axi_rst)
    i_req.rd_stb |=> i_rsp.rd_valid)
    else $error("rd_valid did not follow rd_stb by one cycle");

  a_rd_valid_only: assert property (@(posedge i_axi_clk) disable iff (i_axi_rst)
    !i_req.rd_stb |=> !i_rsp.rd_valid)
    else $error("rd_valid raised without a read one cycle before");

  a_reset_quiet: assert property (@(posedge i_axi_clk)
    i_axi_rst |=> (!i_tap_delay_rst && !i_serdes_clk_rst && (i_trigger == '0)))
    else $error("strobe or trigger high during reset");

  // Disabled trigger must stay low on every camera
  a_trig_disabled: assert property (@(posedge i_axi_clk) disable iff (i_axi_rst)
    !r_trig_en |-> (i_trigger == '0))
    else $error("trigger high while trigger enable is low");

endmodule

bind cam_ctrl_top cam_ctrl_sva u_sva (
  .i_axi_clk        (i_axi_clk),
  .i_axi_rst        (w_axi_rst),
  .i_req            (i_req),
  .i_rsp            (o_rsp),
  .i_trigger        (o_trigger),
  .i_tap_delay_rst  (o_tap_delay_rst),
  .i_serdes_clk_rst (o_serdes_clk_rst)
);

/* tb_cam_ctrl.sv */
/*
  Self-checking testbench for cam_ctrl_top. Random register traffic and trigger
  runs, with every output compared each cycle against a model of the registers.
*/
`include "cam_ctrl_config.svh"

module tb_cam_ctrl
  import cam_ctrl_pkg::*;
();

  localparam int CLK_PERIOD = 40;
  localparam int NUM_OPS    = 2000;
  localparam int TAPS       = `CAM_COUNT * `LANE_COUNT;

  logic                                          axi_clk;
  logic                                          axi_rst;
  reg_req_t                                      req;
  reg_rsp_t                                      rsp;
  logic [`CAM_COUNT-1:0]                         trigger;
  logic [`CAM_COUNT-1:0]                         power_en;
  logic                                          xclear_n;
  logic                                          tap_delay_rst;
  logic                                          serdes_clk_rst;
  logic [`CAM_COUNT-1:0][`LANE_COUNT*`TAP_W-1:0] tap_data;

  // Register contents and trigger counters as the DUT should hold them
  logic              m_clear;
  logic              m_trig_en;
  logic [2:0]        m_power;
  logic [31:0]       m_width;
  logic [31:0]       m_period;
  logic [`TAP_W-1:0] m_tap [TAPS];
  logic [31:0]       m_count [`CAM_COUNT];
  logic              exp_rd_valid;
  logic [31:0]       exp_rdata;
  logic              exp_addr_err;
  logic              exp_tap_rst;
  logic              exp_serdes_rst;
  logic              checks_on = 1'b0;
  int                n_cycles = 0;
  int                n_errors = 0;

  cam_ctrl_top dut0 (
    .i_axi_clk        (axi_clk),
    .i_axi_rst        (axi_rst),
    .i_req            (req),
    .o_rsp            (rsp),
    .o_trigger        (trigger),
    .o_power_en       (power_en),
    .o_xclear_n       (xclear_n),
    .o_tap_delay_rst  (tap_delay_rst),
    .o_serdes_clk_rst (serdes_clk_rst),
    .o_tap_data       (tap_data)
  );

  initial begin
    axi_clk = 1'b0;
    forever #(CLK_PERIOD / 2) axi_clk = ~axi_clk;
  end

  // Bound of four cycles per request plus margin
  initial begin
    #(NUM_OPS * 4 * CLK_PERIOD + 100 * CLK_PERIOD);
    $display("Timeout: the test sequence did not finish in time");
    $display("ERRORS FOUND");
    $finish;
  end

  task automatic report_mismatch(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
    n_errors++;
    $display("Error at %0t: %s is %0h, expected %0h", $time, name, got, exp);
  endtask

  function automatic logic [31:0] model_read(input logic [7:0] addr);
    logic [31:0] v;
    v = '0;
    if (addr == REG_CONTROL) begin
      v[CTRL_CLEAR]   = m_clear;
      v[CTRL_TRIG_EN] = m_trig_en;
      v[CTRL_POWER2:CTRL_POWER0] = m_power;
    end else if (addr == REG_TRIG_WIDTH) v = m_width;
    else if (addr == REG_TRIG_PERIOD) v = m_period;
    else if (addr == REG_CAM_COUNT) v = 32'd3;
    else if (addr == REG_LANE_COUNT) v = 32'd8;
    else if (addr >= 8'd16 && addr < 8'd40) v = 32'(m_tap[int'(addr) - 16]);
    else if (addr == REG_VERSION)
      v = (32'(`VER_MAJOR) << 28) | (32'(`VER_MINOR) << 20) | (32'(`VER_REV) << 16);
    return v;
  endfunction

  function automatic logic [`LANE_COUNT*`TAP_W-1:0] tap_word(input int cam);
    logic [`LANE_COUNT*`TAP_W-1:0] w;
    for (int l = 0; l < `LANE_COUNT; l++) w[l*`TAP_W +: `TAP_W] = m_tap[cam*`LANE_COUNT + l];
    return w;
  endfunction

  // Outputs are stable at the falling edge; check them, then advance the model
  always @(negedge axi_clk) begin : model_step
    logic [`CAM_COUNT-1:0] exp_trig;
    logic                  ctrl_wr;
    logic                  restart;
    if (checks_on) begin
      n_cycles++;
      if (rsp.rd_valid !== exp_rd_valid)
        report_mismatch("o_rsp.rd_valid", 64'(rsp.rd_valid), 64'(exp_rd_valid));
      if (exp_rd_valid && rsp.rdata !== exp_rdata)
        report_mismatch("o_rsp.rdata", 64'(rsp.rdata), 64'(exp_rdata));
      if (rsp.addr_err !== exp_addr_err)
        report_mismatch("o_rsp.addr_err", 64'(rsp.addr_err), 64'(exp_addr_err));
      if (tap_delay_rst !== exp_tap_rst)
        report_mismatch("o_tap_delay_rst", 64'(tap_delay_rst), 64'(exp_tap_rst));
      if (serdes_clk_rst !== exp_serdes_rst)
        report_mismatch("o_serdes_clk_rst", 64'(serdes_clk_rst), 64'(exp_serdes_rst));
      if (power_en !== m_power)
        report_mismatch("o_power_en", 64'(power_en), 64'(m_power));
      if (xclear_n !== !m_clear)
        report_mismatch("o_xclear_n", 64'(xclear_n), 64'(!m_clear));
      for (int c = 0; c < `CAM_COUNT; c++) begin
        exp_trig[c] = m_trig_en && (m_count[c] < m_width);
        if (tap_data[c] !== tap_word(c))
          report_mismatch($sformatf("o_tap_data[%0d]", c), 64'(tap_data[c]), 64'(tap_word(c)));
      end
      if (trigger !== exp_trig)
        report_mismatch("o_trigger", 64'(trigger), 64'(exp_trig));
    end
    if (axi_rst) begin
      m_clear   = 1'b0;
      m_trig_en = 1'b0;
      m_power   = '0;
      m_width   = `DEFAULT_TRIG_LEN;
      m_period  = `DEFAULT_TRIG_PERIOD;
      for (int i = 0; i < TAPS; i++) m_tap[i] = '0;
      for (int c = 0; c < `CAM_COUNT; c++) m_count[c] = '0;
      exp_rd_valid   = 1'b0;
      exp_addr_err   = 1'b0;
      exp_tap_rst    = 1'b0;
      exp_serdes_rst = 1'b0;
      checks_on      = 1'b1;
    end else begin
      ctrl_wr        = req.wr_stb && (req.addr == REG_CONTROL);
      restart        = ctrl_wr && req.wdata[CTRL_CAM_RST];
      exp_rd_valid   = req.rd_stb;
      exp_addr_err   = (req.rd_stb || req.wr_stb) && (req.addr > 8'd40);
      exp_tap_rst    = ctrl_wr && req.wdata[CTRL_TAP_RST];
      exp_serdes_rst = ctrl_wr && req.wdata[CTRL_SERDES_RST];
      if (req.rd_stb) exp_rdata = model_read(req.addr);
      // Counters see the enable and period from before this write
      for (int c = 0; c < `CAM_COUNT; c++) begin
        if (!m_trig_en || restart) m_count[c] = '0;
        else if (m_count[c] >= m_period - 32'd1) m_count[c] = '0;
        else m_count[c] = m_count[c] + 32'd1;
      end
      if (ctrl_wr) begin
        m_clear   = req.wdata[CTRL_CLEAR];
        m_trig_en = req.wdata[CTRL_TRIG_EN];
        m_power   = req.wdata[CTRL_POWER2:CTRL_POWER0];
      end
      if (req.wr_stb && req.addr == REG_TRIG_WIDTH) m_width = req.wdata;
      if (req.wr_stb && req.addr == REG_TRIG_PERIOD) m_period = req.wdata;
      if (req.wr_stb && req.addr >= 8'd16 && req.addr < 8'd40)
        m_tap[int'(req.addr) - 16] = req.wdata[`TAP_W-1:0];
    end
  end

  task automatic send_req(input logic wr, input logic rd, input logic [7:0] addr,
                          input logic [31:0] data);
    reg_req_t r;
    r.wr_stb = wr;
    r.rd_stb = rd;
    r.addr   = addr;
    r.wdata  = data;
    @(posedge axi_clk);
    req <= r;
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge axi_clk);
      req <= '0;
    end
  endtask

  function automatic logic [7:0] pick_rw_addr();
    case ($urandom_range(3))
      0: return REG_CONTROL;
      1: return REG_TRIG_WIDTH;
      2: return REG_TRIG_PERIOD;
      default: return 8'(16 + $urandom_range(TAPS - 1));
    endcase
  endfunction

  initial begin
    logic [7:0]  addr;
    logic [31:0] ctrl;
    void'($urandom(32'h5bb9_9ad9));
    req     = '0;
    axi_rst = 1'b1;
    repeat (2) @(posedge axi_clk);
    axi_rst <= 1'b0;
    // Write then read back writable registers
    repeat (600) begin
      addr = pick_rw_addr();
      send_req(1'b1, 1'b0, addr, $urandom);
      send_req(1'b0, 1'b1, addr, '0);
      idle($urandom_range(1));
    end
    // Read-only, unmapped and out-of-range addresses
    send_req(1'b1, 1'b0, 8'd1, $urandom);
    send_req(1'b1, 1'b0, REG_VERSION, $urandom);
    send_req(1'b0, 1'b1, REG_CAM_COUNT, '0);
    send_req(1'b0, 1'b1, REG_LANE_COUNT, '0);
    send_req(1'b0, 1'b1, REG_VERSION, '0);
    repeat (200) begin
      case ($urandom_range(2))
        0: send_req(1'b0, 1'b1, 8'($urandom_range(255)), '0);
        1: send_req(1'b1, 1'b0, 8'($urandom_range(5, 15)), $urandom);
        default: send_req(1'b1, 1'b0, 8'($urandom_range(41, 255)), $urandom);
      endcase
      send_req(1'b0, 1'b1, pick_rw_addr(), '0);
      idle($urandom_range(1));
    end
    // Short trigger periods, then a camera reset in mid-period
    repeat (20) begin
      ctrl = $urandom & ~((32'd1 << CTRL_TRIG_EN) | (32'd1 << CTRL_CAM_RST));
      send_req(1'b1, 1'b0, REG_CONTROL, ctrl);
      send_req(1'b1, 1'b0, REG_TRIG_WIDTH, 32'($urandom_range(1, 6)));
      send_req(1'b1, 1'b0, REG_TRIG_PERIOD, 32'($urandom_range(2, 16)));
      send_req(1'b1, 1'b0, REG_CONTROL, ctrl | (32'd1 << CTRL_TRIG_EN));
      idle($urandom_range(10, 50));
      send_req(1'b1, 1'b0, REG_CONTROL,
               ctrl | (32'd1 << CTRL_TRIG_EN) | (32'd1 << CTRL_CAM_RST));
      idle($urandom_range(10, 50));
    end
    idle(4);
    $display("Cycles checked: %0d, errors: %0d", n_cycles, n_errors);
    if (n_errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

/* cam_ctrl_top.f */
+incdir+.
cam_ctrl_pkg.sv
cam_reg_file.sv
cam_trigger_gen.sv
cam_ctrl_top.sv
cam_ctrl_sva.sv
tb_cam_ctrl.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and scans the log for the fail message
set -e
set -o pipefail
cd "$(dirname "$0")"
verilator --binary --assert --top-module tb_cam_ctrl -f cam_ctrl_top.f
./obj_dir/Vtb_cam_ctrl 2>&1 | tee sim.log
if grep -q "ERRORS FOUND" sim.log; then
  echo "Simulation failed"
  exit 1
fi
echo "Simulation passed"
